// File: filelist.f
+incdir+include
hdl/aes_pkg.sv
hdl/aes_block_in.sv
hdl/aes_key_sched.sv
hdl/aes_cipher_core.sv
hdl/aes_top.sv
dv/aes_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the AES testbench with Verilator and runs it.
# The exit status is nonzero when the build or any check fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module aes_tb \
  -f filelist.f \
  --Mdir obj_dir \
  -o aes_tb_sim

./obj_dir/aes_tb_sim

// File: dv/aes_tb.sv
// Self-checking testbench for the AES-128 engine. Applies a table of
// configuration and block entries in order and compares each result with
// the published FIPS-197 and SP 800-38A AES-128 vectors.

`default_nettype none

`include "aes_defs.svh"

module aes_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import aes_pkg::*;

  ////////////////////////////////////////
  // Reference vectors
  ////////////////////////////////////////

  localparam aes_key_t   FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_block_t FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_block_t FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  localparam aes_key_t   SP_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam aes_block_t CBC_IV = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_block_t CTR_IV = 128'hf0f1f2f3f4f5f6f7f8f9fafbfcfdfeff;

  localparam aes_block_t SP_PT [4] = '{
    128'h6bc1bee22e409f96e93d7e117393172a,
    128'hae2d8a571e03ac9c9eb76fac45af8e51,
    128'h30c81c46a35ce411e5fbc1191a0a52ef,
    128'hf69f2445df4f9b17ad2b417be66c3710
  };
  localparam aes_block_t ECB_CT [4] = '{
    128'h3ad77bb40d7a3660a89ecaf32466ef97,
    128'hf5d3d58503b9699de785895a96fdbaaf,
    128'h43b1cd7f598ece23881b00e3ed030688,
    128'h7b0c785e27e8ad3f8223207104725dd4
  };
  localparam aes_block_t CBC_CT [4] = '{
    128'h7649abac8119b246cee98e9b12e9197d,
    128'h5086cb9b507219ee95db113a917678b2,
    128'h73bed6b8e3c1743b7116e69e22229516,
    128'h3ff1caa1681fac09120eca307586e1a7
  };
  localparam aes_block_t CTR_CT [4] = '{
    128'h874d6191b620e3261bef6864990db6ce,
    128'h9806f66b7970fdff8617187bb9fffdff,
    128'h5ae4df3edbd5d35e5b4f09020db03eab,
    128'h1e031dda2fbe03d1792170a0f3009cee
  };

  // Start to valid_o: load cycle plus one cycle per round
  localparam int LATENCY = `AES_NUM_ROUNDS + 1;

  localparam logic KIND_CFG   = 1'b0;
  localparam logic KIND_BLOCK = 1'b1;

  typedef struct packed {
    logic       kind;
    logic [1:0] mode;
    aes_key_t   key;
    aes_block_t iv;
    aes_block_t data;
    aes_block_t expected;
    logic       disturb;
  } entry_t;

  logic       clk_i = 1'b0;
  logic       reset_i;
  logic       cfg_we_i;
  logic [1:0] mode_i;
  aes_key_t   key_i;
  aes_block_t iv_i;
  logic       start_i;
  aes_block_t data_i;
  logic       ready_o;
  logic       valid_o;
  aes_block_t data_o;

  entry_t entries [$];
  int     num_entries = 0;
  int     starts = 0;
  int     valid_pulses = 0;
  integer seed;

  aes_top u_aes_top (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cfg_we_i(cfg_we_i),
    .mode_i  (mode_i),
    .key_i   (key_i),
    .iv_i    (iv_i),
    .start_i (start_i),
    .data_i  (data_i),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .data_o  (data_o)
  );

  always #50 clk_i = ~clk_i;

  // Counts the cycles with valid_o high
  always @(posedge clk_i) begin
    if (valid_o) begin
      valid_pulses <= valid_pulses + 1;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_block(input aes_block_t actual, input aes_block_t expected,
                             input string msg);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
      $display("tests failed");
      $fatal(1, "block compare error");
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string msg);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %b expected %b", $time, msg, actual, expected);
      $display("tests failed");
      $fatal(1, "bit compare error");
    end
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  function automatic void add_cfg(input logic [1:0] mode, input aes_key_t key,
                                  input aes_block_t iv);
    entry_t e;
    e = '{KIND_CFG, mode, key, iv, '0, '0, 1'b0};
    entries.push_back(e);
  endfunction

  function automatic void add_block(input aes_block_t data, input aes_block_t expected,
                                    input logic disturb);
    entry_t e;
    e = '{KIND_BLOCK, 2'b00, '0, '0, data, expected, disturb};
    entries.push_back(e);
  endfunction

  function automatic void build_table();
    add_cfg(2'b00, FIPS_KEY, '0);
    add_block(FIPS_PT, FIPS_CT, 1'b0);
    add_cfg(2'b00, SP_KEY, '0);
    for (int i = 0; i < 4; i++) begin
      add_block(SP_PT[i], ECB_CT[i], 1'b0);
    end
    add_cfg(2'b01, SP_KEY, CBC_IV);
    for (int i = 0; i < 4; i++) begin
      add_block(SP_PT[i], CBC_CT[i], 1'b0);
    end
    add_cfg(2'b10, SP_KEY, CTR_IV);
    for (int i = 0; i < 4; i++) begin
      add_block(SP_PT[i], CTR_CT[i], 1'b0);
    end
    // Start and config pulses while busy must be dropped
    add_cfg(2'b00, SP_KEY, '0);
    add_block(SP_PT[0], ECB_CT[0], 1'b1);
    add_block(SP_PT[1], ECB_CT[1], 1'b0);
    // Unsupported mode encoding falls back to ECB
    add_cfg(2'b11, FIPS_KEY, CTR_IV);
    add_block(FIPS_PT, FIPS_CT, 1'b0);
  endfunction

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  task automatic apply_cfg(input entry_t e);
    check_bit(ready_o, 1'b1, "ready_o low at configuration");
    cfg_we_i = 1'b1;
    mode_i   = e.mode;
    key_i    = e.key;
    iv_i     = e.iv;
    @(posedge clk_i);
    #5;
    cfg_we_i = 1'b0;
  endtask

  task automatic run_block(input entry_t e);
    int cycles;
    check_bit(ready_o, 1'b1, "ready_o low before start");
    start_i = 1'b1;
    data_i  = e.data;
    @(posedge clk_i);
    #5;
    start_i = 1'b0;
    starts++;
    check_bit(ready_o, 1'b0, "ready_o high after accepted start");
    cycles = 0;
    do begin
      @(posedge clk_i);
      #5;
      cycles++;
      if (e.disturb && (cycles == 3 || cycles == 5)) begin
        check_bit(ready_o, 1'b0, "ready_o high while block in flight");
      end
      // Different mode, key, IV and data for both dropped pulses
      if (e.disturb && cycles == 3) begin
        data_i = ~e.data;
        mode_i = 2'b10;
        key_i  = ~key_i;
        iv_i   = ~iv_i;
      end
      // Start pulse first, config pulse two cycles later
      start_i  = e.disturb && cycles == 3;
      cfg_we_i = e.disturb && cycles == 5;
    end while (!valid_o && cycles < 2 * LATENCY);
    if (!valid_o) begin
      $display("No valid_o within %0d cycles of start at %0t ns", 2 * LATENCY, $time);
      $display("tests failed");
      $fatal(1, "missing result");
    end
    check_bit(cycles == LATENCY, 1'b1,
              $sformatf("start to valid_o took %0d cycles", cycles));
    check_block(data_o, e.expected, "result block");
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin : main
    integer gap;
    reset_i  = 1'b1;
    cfg_we_i = 1'b0;
    mode_i   = 2'b00;
    key_i    = '0;
    iv_i     = '0;
    start_i  = 1'b0;
    data_i   = '0;
    seed     = 32'h94d07737;
    build_table();
    num_entries = entries.size();
    repeat (10) @(posedge clk_i);
    #5;
    reset_i = 1'b0;
    check_bit(ready_o, 1'b1, "ready_o after reset");
    check_bit(valid_o, 1'b0, "valid_o after reset");
    foreach (entries[i]) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) begin
        @(posedge clk_i);
        #5;
      end
      if (entries[i].kind == KIND_CFG) begin
        apply_cfg(entries[i]);
      end else begin
        run_block(entries[i]);
      end
    end
    @(posedge clk_i);
    #5;
    check_bit(valid_o, 1'b0, "valid_o high after last result");
    check_bit(valid_pulses == starts, 1'b1, "valid_o pulse count against accepted starts");
    $display("all tests passed");
    $finish;
  end

  initial begin : watchdog
    wait (num_entries > 0);
    repeat (num_entries * 16 + 50) @(posedge clk_i);
    $display("Run did not finish within %0d cycles", num_entries * 16 + 50);
    $display("tests failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

// File: hdl/aes_top.sv
// Top level of the AES-128 engine. Connects the input stage, which
// handles configuration and mode chaining, to the iterative cipher core.

`default_nettype none

module aes_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                cfg_we_i,
  input  logic [1:0]          mode_i,
  input  aes_pkg::aes_key_t   key_i,
  input  aes_pkg::aes_block_t iv_i,
  input  logic                start_i,
  input  aes_pkg::aes_block_t data_i,
  output logic                ready_o,
  output logic                valid_o,
  output aes_pkg::aes_block_t data_o
);
  import aes_pkg::*;

  logic       blk_valid;
  aes_block_t blk_state;
  aes_block_t blk_mask;
  aes_key_t   blk_key;
  logic       res_valid;
  aes_block_t res_data;

  aes_block_in u_block_in (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cfg_we_i    (cfg_we_i),
    .mode_i      (mode_i),
    .key_i       (key_i),
    .iv_i        (iv_i),
    .start_i     (start_i),
    .data_i      (data_i),
    .res_valid_i (res_valid),
    .res_data_i  (res_data),
    .ready_o     (ready_o),
    .blk_valid_o (blk_valid),
    .blk_state_o (blk_state),
    .blk_mask_o  (blk_mask),
    .key_o       (blk_key)
  );

  aes_cipher_core u_cipher_core (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (blk_valid),
    .state_i     (blk_state),
    .mask_i      (blk_mask),
    .key_i       (blk_key),
    .out_valid_o (res_valid),
    .data_o      (res_data)
  );

  // Results go straight out and back for chaining
  assign valid_o = res_valid;
  assign data_o  = res_data;

endmodule

`default_nettype wire

// File: hdl/aes_cipher_core.sv
// Iterative AES-128 encryption, one round per cycle. Loads the input
// block XOR key, runs ten rounds, adds the mask to the final state and
// registers the result with a one-cycle valid pulse.

`default_nettype none

`include "aes_defs.svh"

module aes_cipher_core (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                in_valid_i,
  input  aes_pkg::aes_block_t state_i,
  input  aes_pkg::aes_block_t mask_i,
  input  aes_pkg::aes_key_t   key_i,
  output logic                out_valid_o,
  output aes_pkg::aes_block_t data_o
);
  import aes_pkg::*;

  aes_block_t state_q;
  aes_round_t round_q;
  logic       run_q;
  logic       last_round;
  aes_key_t   round_key;
  aes_block_t shifted;
  aes_block_t mixed;
  aes_block_t round_out;
  logic       out_valid_q;
  aes_block_t data_q;

  aes_key_sched u_key_sched (
    .clk_i       (clk_i),
    .load_i      (in_valid_i),
    .step_i      (run_q),
    .key_i       (key_i),
    .round_key_o (round_key)
  );

  ////////////////////////////////////////
  // Round function
  ////////////////////////////////////////

  assign last_round = (round_q == aes_round_t'(`AES_NUM_ROUNDS));
  assign shifted    = shift_rows(sub_bytes(state_q));
  // No MixColumns in the final round
  assign mixed      = last_round ? shifted : mix_columns(shifted);
  assign round_out  = mixed ^ round_key;

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      run_q       <= 1'b0;
      round_q     <= '0;
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= run_q & last_round;
      if (in_valid_i) begin
        run_q   <= 1'b1;
        round_q <= aes_round_t'(1);
      end else if (run_q) begin
        if (last_round) begin
          run_q   <= 1'b0;
          round_q <= '0;
        end else begin
          round_q <= round_q + 1'b1;
        end
      end
    end
  end

  // State and result registers
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      // Initial AddRoundKey
      state_q <= state_i ^ key_i;
    end else if (run_q) begin
      state_q <= round_out;
    end
    if (run_q && last_round) begin
      data_q <= round_out ^ mask_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign data_o      = data_q;

endmodule

`default_nettype wire

// File: hdl/aes_key_sched.sv
// On-the-fly AES-128 key expansion. Load with the cipher key, then step
// once per round. The output is the key for the round applied next.

`default_nettype none

`include "aes_defs.svh"

module aes_key_sched (
  input  logic              clk_i,
  input  logic              load_i,
  input  logic              step_i,
  input  aes_pkg::aes_key_t key_i,
  output aes_pkg::aes_key_t round_key_o
);
  import aes_pkg::*;

  aes_key_t   rk_q;
  aes_key_t   rk_next;
  logic [7:0] rcon_q;
  aes_word_t  w [4];
  aes_word_t  n [4];
  aes_word_t  t;

  // Split the current key into its four words
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      w[i] = rk_q[`AES_KEY_W - 1 - i * `AES_WORD_W -: `AES_WORD_W];
    end
  end

  // Standard AES-128 expansion step
  always_comb begin
    t    = sub_word(rot_word(w[3])) ^ {rcon_q, 24'h000000};
    n[0] = w[0] ^ t;
    n[1] = w[1] ^ n[0];
    n[2] = w[2] ^ n[1];
    n[3] = w[3] ^ n[2];
  end

  assign rk_next = {n[0], n[1], n[2], n[3]};

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      rk_q   <= key_i;
      rcon_q <= 8'h01;
    end else if (step_i) begin
      rk_q   <= rk_next;
      rcon_q <= xtime(rcon_q);
    end
  end

  assign round_key_o = rk_next;

endmodule

`default_nettype wire

// File: hdl/aes_block_in.sv
// Input stage of the AES engine. Holds mode, key and IV or counter,
// forms the cipher input and output mask for the selected mode and
// hands each accepted block to the cipher core with a one-cycle pulse.

`default_nettype none

module aes_block_in (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               cfg_we_i,
  input  logic [1:0]         mode_i,
  input  aes_pkg::aes_key_t  key_i,
  input  aes_pkg::aes_block_t iv_i,
  input  logic               start_i,
  input  aes_pkg::aes_block_t data_i,
  input  logic               res_valid_i,
  input  aes_pkg::aes_block_t res_data_i,
  output logic               ready_o,
  output logic               blk_valid_o,
  output aes_pkg::aes_block_t blk_state_o,
  output aes_pkg::aes_block_t blk_mask_o,
  output aes_pkg::aes_key_t  key_o
);
  import aes_pkg::*;

  aes_mode_e  mode_q, mode_d;
  aes_key_t   key_q;
  aes_block_t iv_q, iv_cur;
  logic       busy_q, start_acc, cfg_acc;
  logic       blk_valid_q;
  aes_block_t blk_state_q, blk_mask_q;

  // Free again in the cycle the result comes back
  assign ready_o   = ~busy_q | res_valid_i;
  assign start_acc = start_i & ready_o;
  // A start in the same cycle takes precedence over a config write
  assign cfg_acc   = cfg_we_i & ready_o & ~start_i;

  always_comb begin
    unique case (mode_i)
      2'b01:   mode_d = AES_CBC;
      2'b10:   mode_d = AES_CTR;
      default: mode_d = AES_ECB;
    endcase
  end

  // CBC chaining value, bypassed when the previous result lands now
  assign iv_cur = (res_valid_i && mode_q == AES_CBC) ? res_data_i : iv_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_q      <= AES_ECB;
      key_q       <= '0;
      iv_q        <= '0;
      busy_q      <= 1'b0;
      blk_valid_q <= 1'b0;
    end else begin
      blk_valid_q <= start_acc;
      if (start_acc) begin
        busy_q <= 1'b1;
      end else if (res_valid_i) begin
        busy_q <= 1'b0;
      end
      if (cfg_acc) begin
        mode_q <= mode_d;
        key_q  <= key_i;
        iv_q   <= iv_i;
      end else if (start_acc && mode_q == AES_CTR) begin
        iv_q <= iv_q + 1'b1;
      end else if (res_valid_i && mode_q == AES_CBC) begin
        iv_q <= res_data_i;
      end
    end
  end

  // Cipher input and output mask per mode
  always_ff @(posedge clk_i) begin
    if (start_acc) begin
      unique case (mode_q)
        AES_CBC: begin
          blk_state_q <= data_i ^ iv_cur;
          blk_mask_q  <= '0;
        end
        AES_CTR: begin
          blk_state_q <= iv_q;
          blk_mask_q  <= data_i;
        end
        default: begin
          blk_state_q <= data_i;
          blk_mask_q  <= '0;
        end
      endcase
    end
  end

  assign blk_valid_o = blk_valid_q;
  assign blk_state_o = blk_state_q;
  assign blk_mask_o  = blk_mask_q;
  assign key_o       = key_q;

endmodule

`default_nettype wire

// File: hdl/aes_pkg.sv
// Shared types and round-transform functions for the AES-128 engine.
// Blocks are in FIPS-197 byte order with byte 0 in the top bits and the
// state stored column by column.

`default_nettype none

`include "aes_defs.svh"

package aes_pkg;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [`AES_BLOCK_W-1:0] aes_block_t;
  typedef logic [`AES_KEY_W-1:0]   aes_key_t;
  typedef logic [`AES_WORD_W-1:0]  aes_word_t;
  typedef logic [3:0]              aes_round_t;

  // Encoding 2'b11 is not supported
  typedef enum logic [1:0] {
    AES_ECB = 2'b00,
    AES_CBC = 2'b01,
    AES_CTR = 2'b10
  } aes_mode_e;

  ////////////////////////////////////////
  // S-box
  ////////////////////////////////////////

  // Forward S-box, entry 0 in the top byte
  localparam logic [2047:0] SBOX_TABLE = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [7:0] sbox(input logic [7:0] b);
    return SBOX_TABLE[2047 - 8 * b -: 8];
  endfunction

  // Multiply by x in GF(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  ////////////////////////////////////////
  // Round transforms
  ////////////////////////////////////////

  function automatic aes_block_t sub_bytes(input aes_block_t s);
    aes_block_t o;
    for (int i = 0; i < 16; i++) begin
      o[8*i +: 8] = sbox(s[8*i +: 8]);
    end
    return o;
  endfunction

  // Row r rotates left by r columns
  function automatic aes_block_t shift_rows(input aes_block_t s);
    aes_block_t o;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        o[127 - 8 * (4 * c + r) -: 8] = s[127 - 8 * (4 * ((c + r) % 4) + r) -: 8];
      end
    end
    return o;
  endfunction

  function automatic aes_block_t mix_columns(input aes_block_t s);
    aes_block_t o;
    aes_word_t  w;
    logic [7:0] a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
      w  = s[127 - 32 * c -: 32];
      a0 = w[31:24];
      a1 = w[23:16];
      a2 = w[15:8];
      a3 = w[7:0];
      o[127 - 32 * c -: 32] = {
        xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
        a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
        a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
        xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
      };
    end
    return o;
  endfunction

  ////////////////////////////////////////
  // Key schedule helpers
  ////////////////////////////////////////

  function automatic aes_word_t sub_word(input aes_word_t w);
    aes_word_t o;
    for (int i = 0; i < 4; i++) begin
      o[8*i +: 8] = sbox(w[8*i +: 8]);
    end
    return o;
  endfunction

  function automatic aes_word_t rot_word(input aes_word_t w);
    return {w[23:0], w[31:24]};
  endfunction

endpackage

`default_nettype wire

// File: include/aes_defs.svh
// Width and round-count macros for the AES-128 encryption engine.
// Include this header wherever block, key or word sizes are needed.

`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

////////////////////////////////////////
// Data path widths
////////////////////////////////////////

// One cipher block
`define AES_BLOCK_W 128

// Cipher key, AES-128 only
`define AES_KEY_W 128

// One state column, also one key schedule word
`define AES_WORD_W 32

////////////////////////////////////////
// Cipher length
////////////////////////////////////////

`define AES_NUM_ROUNDS 10

`endif
